/* id_stage.f */
+incdir+test
verilog/id_pkg.sv
verilog/regfile.sv
verilog/inst_decoder.sv
verilog/operand_forward.sv
verilog/branch_unit.sv
verilog/id_stage_latch.sv
verilog/id_stage.sv
test/id_stage_tb.sv

/* test/id_stage_tb_model.svh */
`ifndef ID_STAGE_TB_MODEL_SVH
`define ID_STAGE_TB_MODEL_SVH

// fields the decoder must produce for an ALU-type instruction
typedef struct packed {
    alu_op_e   alu_op;
    logic      src1_is_pc;
    logic      src2_is_imm;
    logic      res_from_mem;
    logic      gr_we;
    logic      mem_we;
    reg_addr_t dest;
    xlen_t     imm;
} exp_dec_t;

// kind 0..10 three-register, 11..13 shift by immediate, 14..19 12-bit immediate,
// 20 lu12i.w, 21 pcaddu12i, 22 an opcode outside the kept set, 23 ld.w, 24 st.w
localparam logic [4:0] RRR_OP5 [11] = '{5'h00, 5'h02, 5'h04, 5'h05, 5'h08, 5'h09,
                                        5'h0a, 5'h0b, 5'h0e, 5'h0f, 5'h10};
localparam alu_op_e    RRR_OP [11]  = '{ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND,
                                        ALU_OR, ALU_XOR, ALU_SLL, ALU_SRL, ALU_SRA};
localparam logic [4:0] SHIFT_OP5 [3] = '{5'h01, 5'h09, 5'h11};
localparam alu_op_e    SHIFT_OP [3]  = '{ALU_SLL, ALU_SRL, ALU_SRA};
localparam logic [3:0] IMM_OP4 [6]   = '{4'h8, 4'h9, 4'ha, 4'hd, 4'he, 4'hf};
localparam alu_op_e    IMM_OP [6]    = '{ALU_SLT, ALU_SLTU, ALU_ADD, ALU_AND, ALU_OR, ALU_XOR};
// beq bne blt bge bltu bgeu b bl jirl
localparam logic [5:0] BR_OP6 [9] = '{6'h16, 6'h17, 6'h18, 6'h19, 6'h1a, 6'h1b,
                                      6'h14, 6'h15, 6'h13};

function automatic xlen_t rrr_word(logic [4:0] op5, reg_addr_t rd, reg_addr_t rj, reg_addr_t rk);
    return {6'h00, 4'h0, 2'h1, op5, rk, rj, rd};
endfunction

function automatic xlen_t shift_word(logic [4:0] op5, reg_addr_t rd, reg_addr_t rj,
                                     logic [4:0] ui5);
    return {6'h00, 4'h1, 2'h0, op5, ui5, rj, rd};
endfunction

function automatic xlen_t imm12_word(logic [5:0] op6, logic [3:0] op4, logic [11:0] i12,
                                     reg_addr_t rj, reg_addr_t rd);
    return {op6, op4, i12, rj, rd};
endfunction

function automatic xlen_t upper_word(logic [5:0] op6, logic [19:0] i20, reg_addr_t rd);
    return {op6, 1'b0, i20, rd};
endfunction

function automatic void alu_case(input int kind, input xlen_t r1, input xlen_t r2,
                                 output xlen_t inst, output exp_dec_t e);
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [19:0] i20;
    rd = r1[4:0];
    rj = r1[9:5];
    rk = r1[14:10];
    i12 = r2[11:0];
    i20 = r2[31:12];
    e = '0;
    e.dest = rd;
    e.gr_we = 1'b1;
    if (kind < 11) begin
        inst = rrr_word(RRR_OP5[kind], rd, rj, rk);
        e.alu_op = RRR_OP[kind];
    end else if (kind < 14) begin
        inst = shift_word(SHIFT_OP5[kind - 11], rd, rj, rk);
        e.alu_op = SHIFT_OP[kind - 11];
        e.src2_is_imm = 1'b1;
        e.imm = {27'b0, rk};
    end else if (kind < 20) begin
        inst = imm12_word(6'h00, IMM_OP4[kind - 14], i12, rj, rd);
        e.alu_op = IMM_OP[kind - 14];
        e.src2_is_imm = 1'b1;
        // andi, ori, xori zero-extend
        e.imm = (kind >= 17) ? {20'b0, i12} : {{20{i12[11]}}, i12};
    end else if (kind < 22) begin
        inst = upper_word((kind == 20) ? 6'h05 : 6'h07, i20, rd);
        e.alu_op = (kind == 20) ? ALU_LUI : ALU_ADD;
        e.src1_is_pc = (kind == 21);
        e.src2_is_imm = 1'b1;
        e.imm = {i20, 12'b0};
    end else if (kind > 22) begin
        // address is rj + si12
        inst = imm12_word(6'h0a, (kind == 23) ? 4'h2 : 4'h6, i12, rj, rd);
        e.alu_op = ALU_ADD;
        e.src2_is_imm = 1'b1;
        e.imm = {{20{i12[11]}}, i12};
        e.res_from_mem = (kind == 23);
        e.gr_we = (kind == 23);
        e.mem_we = (kind == 24);
    end else begin
        inst = {6'h3f, r2[25:0]};
        e.gr_we = 1'b0;
    end
endfunction

function automatic xlen_t branch_word(int kind, logic [25:0] offs, reg_addr_t rj, reg_addr_t rd);
    // b and bl carry offs[25:16] in the low ten bits
    if (kind == 6 || kind == 7) begin
        return {BR_OP6[kind], offs[15:0], offs[25:16]};
    end
    return {BR_OP6[kind], offs[15:0], rj, rd};
endfunction

function automatic logic branch_taken(int kind, xlen_t a, xlen_t b);
    case (kind)
        0: return a == b;
        1: return a != b;
        2: return $signed(a) < $signed(b);
        3: return $signed(a) >= $signed(b);
        4: return a < b;
        5: return a >= b;
        default: return 1'b1;
    endcase
endfunction

function automatic xlen_t branch_target(int kind, xlen_t pc, xlen_t a, logic [25:0] offs);
    if (kind == 6 || kind == 7) begin
        return pc + {{4{offs[25]}}, offs, 2'b00};
    end else if (kind == 8) begin
        return a + {{14{offs[15]}}, offs[15:0], 2'b00};
    end
    return pc + {{14{offs[15]}}, offs[15:0], 2'b00};
endfunction

`endif

/* test/id_stage_tb.sv */
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

    localparam int N_ALU = 200;
    localparam int N_BR  = 12;
    // rough cycle cost of every sequence, summed
    localparam int SEQ_CYCLES = N_ALU * 2 + 32 * 3 + 16 * 2 + 6 * 6 + 9 * N_BR * 3 + 4 * 9 + 10;
    localparam int MAX_CYCLES = 2 * SEQ_CYCLES;

    logic      clk = 1'b0;
    logic      reset;
    logic      es_allowin;
    logic      ds_allowin;
    logic      fs_to_ds_valid;
    fs_to_ds_t fs_to_ds_bus;
    es_fwd_t   es_fwd;
    ms_fwd_t   ms_fwd;
    ws_to_rf_t ws_to_rf;
    logic      ds_to_es_valid;
    ds_to_es_t ds_to_es_bus;
    br_bus_t   br_bus;

    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;
    xlen_t rf_model [32];

    `include "id_stage_tb_model.svh"

    id_stage id_stage_i (
        .clk            (clk),
        .reset          (reset),
        .es_allowin     (es_allowin),
        .ds_allowin     (ds_allowin),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_fwd         (es_fwd),
        .ms_fwd         (ms_fwd),
        .ws_to_rf       (ws_to_rf),
        .ds_to_es_valid (ds_to_es_valid),
        .ds_to_es_bus   (ds_to_es_bus),
        .br_bus         (br_bus)
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check(input logic ok, input string msg);
        checks++;
        assert (ok) else begin
            errors++;
            $display("FAILED at %0t ns: %s", $time, msg);
        end
    endtask

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic idle_fwd();
        es_fwd   = '0;
        ms_fwd   = '0;
        ws_to_rf = '0;
    endtask

    // hold the offer until the stage takes it
    task automatic offer(input xlen_t inst, input xlen_t pc);
        logic took;
        fs_to_ds_valid = 1'b1;
        fs_to_ds_bus = '{pc: pc, inst: inst};
        do begin
            @(negedge clk);
            took = ds_allowin;
            step();
        end while (!took);
        fs_to_ds_valid = 1'b0;
    endtask

    task automatic wait_out();
        @(negedge clk);
        while (!ds_to_es_valid) @(negedge clk);
    endtask

    // execute holding the stage must close allowin
    always @(negedge clk) begin
        if (!reset && ds_to_es_valid && !es_allowin) begin
            check(!ds_allowin, "ds_allowin high while execute is not accepting");
        end
    end

    initial begin
        xlen_t       inst;
        xlen_t       a;
        xlen_t       b;
        xlen_t       pc;
        xlen_t       exp_v;
        exp_dec_t    e;
        ds_to_es_t   snap;
        int          kind;
        logic [25:0] offs;
        logic        tk;
        void'($urandom(32'hcc22));
        reset = 1'b1;
        es_allowin = 1'b1;
        fs_to_ds_valid = 1'b0;
        fs_to_ds_bus = '0;
        idle_fwd();
        step();
        step();
        reset = 1'b0;
        @(negedge clk);
        check(ds_allowin && !ds_to_es_valid && !br_bus.taken && !br_bus.cancel && !br_bus.stall,
              "outputs not idle after reset");
        step();

        for (int i = 0; i < N_ALU; i++) begin
            kind = $urandom_range(24);
            alu_case(kind, $urandom, $urandom, inst, e);
            pc = $urandom & 32'hffff_fffc;
            offer(inst, pc);
            wait_out();
            if (kind == 22) begin
                check(!ds_to_es_bus.gr_we && !ds_to_es_bus.mem_we,
                      $sformatf("invalid instruction %h writes", inst));
            end else begin
                check(ds_to_es_bus.alu_op == e.alu_op && ds_to_es_bus.imm == e.imm
                      && ds_to_es_bus.src2_is_imm == e.src2_is_imm && ds_to_es_bus.dest == e.dest
                      && ds_to_es_bus.src1_is_pc == e.src1_is_pc
                      && ds_to_es_bus.res_from_mem == e.res_from_mem
                      && ds_to_es_bus.gr_we == e.gr_we && ds_to_es_bus.mem_we == e.mem_we
                      && ds_to_es_bus.pc == pc,
                      $sformatf("decode of %h: op %0d imm %h, expected op %0d imm %h", inst,
                                ds_to_es_bus.alu_op, ds_to_es_bus.imm, e.alu_op, e.imm));
            end
            step();
        end

        // r0 is written too and must stay zero
        for (int r = 0; r < 32; r++) begin
            exp_v = $urandom;
            rf_model[r] = (r == 0) ? '0 : exp_v;
            ws_to_rf = '{we: 1'b1, waddr: 5'(r), wdata: exp_v};
            step();
        end
        ws_to_rf = '0;
        for (int r = 0; r < 32; r++) begin
            offer(rrr_word(5'h00, 5'd3, 5'(r), 5'd0), 32'h1000);
            wait_out();
            check(ds_to_es_bus.rj_value === rf_model[r],
                  $sformatf("r%0d reads %h, expected %h", r, ds_to_es_bus.rj_value, rf_model[r]));
            step();
        end

        // bit 0 execute, bit 1 memory, bit 2 write-back, bit 3 uses r0
        for (int m = 0; m < 16; m++) begin
            reg_addr_t rr;
            rr = m[3] ? 5'd0 : 5'd7;
            es_fwd = '{valid: m[0], blk: 1'b0, dest: rr, data: $urandom};
            ms_fwd = '{valid: m[1], dest: rr, data: $urandom};
            ws_to_rf = '{we: m[2], waddr: rr, wdata: $urandom};
            if (rr == 0) exp_v = '0;
            else if (m[0]) exp_v = es_fwd.data;
            else if (m[1]) exp_v = ms_fwd.data;
            else if (m[2]) exp_v = ws_to_rf.wdata;
            else exp_v = rf_model[rr];
            if (m[2] && rr != 0) rf_model[rr] = ws_to_rf.wdata;
            offer(rrr_word(5'h00, 5'd4, rr, rr), 32'h1800);
            wait_out();
            check(ds_to_es_bus.rj_value == exp_v && ds_to_es_bus.rkd_value == exp_v,
                  $sformatf("forward case %0d gives %h, expected %h", m,
                            ds_to_es_bus.rj_value, exp_v));
            step();
            idle_fwd();
        end

        for (int i = 0; i < 6; i++) begin
            int hold;
            hold = $urandom_range(1, 4);
            exp_v = $urandom;
            es_fwd = '{valid: 1'b1, blk: 1'b1, dest: 5'd9, data: $urandom};
            case (i % 3)
                0: inst = rrr_word(5'h00, 5'd3, 5'd9, 5'd2);
                1: inst = rrr_word(5'h00, 5'd3, 5'd2, 5'd9);
                default: inst = branch_word(0, 26'h40, 5'd2, 5'd9);
            endcase
            offer(inst, 32'h2000);
            repeat (hold) begin
                @(negedge clk);
                check(!ds_to_es_valid && !ds_allowin, "load-use hazard did not stall the stage");
                check(br_bus.stall == (i % 3 == 2), "branch stall flag wrong during hazard");
                step();
            end
            es_fwd = '{valid: 1'b1, blk: 1'b0, dest: 5'd9, data: exp_v};
            @(negedge clk);
            check(ds_to_es_valid, "instruction not released when load data arrived");
            check(((i % 3 == 0) ? ds_to_es_bus.rj_value : ds_to_es_bus.rkd_value) == exp_v,
                  $sformatf("load data %h not forwarded after stall", exp_v));
            step();
            idle_fwd();
        end

        for (int k = 0; k < 9; k++) begin
            for (int j = 0; j < N_BR; j++) begin
                a = $urandom;
                b = ($urandom_range(3) == 0) ? a : $urandom;
                offs = 26'($urandom);
                pc = $urandom & 32'hffff_fffc;
                es_fwd = '{valid: 1'b1, blk: 1'b0, dest: 5'd12, data: a};
                ms_fwd = '{valid: 1'b1, dest: 5'd13, data: b};
                offer(branch_word(k, offs, 5'd12, 5'd13), pc);
                // wrong-path instruction offered while the branch resolves
                fs_to_ds_valid = 1'b1;
                fs_to_ds_bus = '{pc: pc + 32'd4, inst: rrr_word(5'h00, 5'd6, 5'd0, 5'd0)};
                tk = branch_taken(k, a, b);
                @(negedge clk);
                check(ds_to_es_valid && br_bus.taken == tk,
                      $sformatf("branch kind %0d on %h, %h: taken %b, expected %b",
                                k, a, b, br_bus.taken, tk));
                if (tk) begin
                    check(br_bus.cancel && br_bus.target == branch_target(k, pc, a, offs),
                          $sformatf("branch kind %0d target %h, expected %h", k,
                                    br_bus.target, branch_target(k, pc, a, offs)));
                end
                if (k == 7) check(ds_to_es_bus.dest == 5'd1 && ds_to_es_bus.gr_we,
                                  "bl does not link into r1");
                step();
                fs_to_ds_valid = 1'b0;
                @(negedge clk);
                if (tk) begin
                    check(!ds_to_es_valid, "wrong-path instruction reached execute");
                end else begin
                    check(ds_to_es_valid && ds_to_es_bus.pc == pc + 32'd4,
                          "fall-through instruction lost after untaken branch");
                end
                step();
            end
        end
        idle_fwd();

        for (int i = 0; i < 4; i++) begin
            int hold;
            hold = $urandom_range(2, 5);
            es_allowin = 1'b0;
            alu_case($urandom_range(21), $urandom, $urandom, inst, e);
            offer(inst, 32'h3000 + 32'(i * 8));
            // younger instruction waits on the fetch side
            fs_to_ds_valid = 1'b1;
            fs_to_ds_bus = '{pc: 32'h4000, inst: rrr_word(5'h0a, 5'd8, 5'd0, 5'd0)};
            @(negedge clk);
            snap = ds_to_es_bus;
            repeat (hold) begin
                check(ds_to_es_valid && !ds_allowin && ds_to_es_bus == snap,
                      "stage not held under back-pressure");
                step();
                @(negedge clk);
            end
            step();
            es_allowin = 1'b1;
            @(negedge clk);
            check(ds_allowin && ds_to_es_bus == snap, "held instruction changed before release");
            step();
            fs_to_ds_valid = 1'b0;
            @(negedge clk);
            check(ds_to_es_valid && ds_to_es_bus.pc == 32'h4000,
                  "instruction behind the held one lost");
            step();
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verilog/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit import id_pkg::*; (
    input  decode_t dec,
    input  xlen_t   pc,
    input  xlen_t   rj_value,
    input  xlen_t   rkd_value,
    input  logic    ds_to_es_valid,
    input  logic    ready,
    input  logic    es_allowin,
    output br_bus_t br_bus,
    output logic    cancel
);

    logic [32:0] diff;
    logic        eq;
    logic        lt;
    logic        ltu;
    logic        hit;
    logic        cond_br;
    logic        taken;
    xlen_t       base;

    // rj - rkd, carry out gives the unsigned compare
    assign diff = {1'b0, rj_value} + {1'b0, ~rkd_value} + 33'd1;
    assign eq   = (rj_value == rkd_value);
    assign ltu  = ~diff[32];
    assign lt   = (rj_value[31] & ~rkd_value[31])
                | (~(rj_value[31] ^ rkd_value[31]) & diff[31]);

    always_comb begin
        case (dec.br_kind)
            BR_BEQ:  hit = eq;
            BR_BNE:  hit = ~eq;
            BR_BLT:  hit = lt;
            BR_BGE:  hit = ~lt;
            BR_BLTU: hit = ltu;
            BR_BGEU: hit = ~ltu;
            BR_B, BR_BL, BR_JIRL: hit = 1'b1;
            default: hit = 1'b0;
        endcase
    end

    assign cond_br = dec.br_kind inside {BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    assign taken   = hit & ds_to_es_valid;
    assign cancel  = taken & es_allowin;

    // jirl is register relative
    assign base = (dec.br_kind == BR_JIRL) ? rj_value : pc;

    always_comb begin
        br_bus.stall  = cond_br & ~ready;
        br_bus.taken  = taken;
        br_bus.cancel = cancel;
        br_bus.target = base + dec.br_offs;
    end

endmodule

/* verilog/id_pkg.sv */
package id_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_addr_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_NOR, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE,
        BR_BLTU, BR_BGEU, BR_B, BR_BL, BR_JIRL
    } br_kind_e;

    // inst[31:26]
    typedef enum logic [5:0] {
        OP6_GRP0      = 6'h00,
        OP6_LU12I_W   = 6'h05,
        OP6_PCADDU12I = 6'h07,
        OP6_MEM       = 6'h0a,
        OP6_JIRL      = 6'h13,
        OP6_B         = 6'h14,
        OP6_BL        = 6'h15,
        OP6_BEQ       = 6'h16,
        OP6_BNE       = 6'h17,
        OP6_BLT       = 6'h18,
        OP6_BGE       = 6'h19,
        OP6_BLTU      = 6'h1a,
        OP6_BGEU      = 6'h1b
    } op6_e;

    // inst[25:22], register/immediate group and memory group share the field
    typedef enum logic [3:0] {
        OP4_REG    = 4'h0,
        OP4_SHIFT  = 4'h1,
        OP4_LD_W   = 4'h2,
        OP4_ST_W   = 4'h6,
        OP4_SLTI   = 4'h8,
        OP4_SLTUI  = 4'h9,
        OP4_ADDI_W = 4'ha,
        OP4_ANDI   = 4'hd,
        OP4_ORI    = 4'he,
        OP4_XORI   = 4'hf
    } op4_e;

    // inst[21:20]
    localparam logic [1:0] OP2_SHIFT = 2'h0;
    localparam logic [1:0] OP2_REG3  = 2'h1;

    // inst[19:15], three-register ops
    localparam logic [4:0] OP5_ADD_W = 5'h00;
    localparam logic [4:0] OP5_SUB_W = 5'h02;
    localparam logic [4:0] OP5_SLT   = 5'h04;
    localparam logic [4:0] OP5_SLTU  = 5'h05;
    localparam logic [4:0] OP5_NOR   = 5'h08;
    localparam logic [4:0] OP5_AND   = 5'h09;
    localparam logic [4:0] OP5_OR    = 5'h0a;
    localparam logic [4:0] OP5_XOR   = 5'h0b;
    localparam logic [4:0] OP5_SLL_W = 5'h0e;
    localparam logic [4:0] OP5_SRL_W = 5'h0f;
    localparam logic [4:0] OP5_SRA_W = 5'h10;

    // inst[19:15], shift-by-immediate ops
    localparam logic [4:0] OP5_SLLI_W = 5'h01;
    localparam logic [4:0] OP5_SRLI_W = 5'h09;
    localparam logic [4:0] OP5_SRAI_W = 5'h11;

    typedef struct packed {
        xlen_t pc;
        xlen_t inst;
    } fs_to_ds_t;

    typedef struct packed {
        logic      valid;
        logic      blk;
        reg_addr_t dest;
        xlen_t     data;
    } es_fwd_t;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        xlen_t     data;
    } ms_fwd_t;

    typedef struct packed {
        logic      we;
        reg_addr_t waddr;
        xlen_t     wdata;
    } ws_to_rf_t;

    typedef struct packed {
        alu_op_e   alu_op;
        br_kind_e  br_kind;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        reg_addr_t raddr1;
        reg_addr_t raddr2;
        xlen_t     imm;
        // byte offset of a control-flow instruction, already shifted by 2
        xlen_t     br_offs;
    } decode_t;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src1_is_pc;
        logic      src2_is_imm;
        logic      res_from_mem;
        logic      gr_we;
        logic      mem_we;
        reg_addr_t dest;
        xlen_t     imm;
        xlen_t     rj_value;
        xlen_t     rkd_value;
        xlen_t     pc;
    } ds_to_es_t;

    typedef struct packed {
        logic  stall;
        logic  taken;
        logic  cancel;
        xlen_t target;
    } br_bus_t;

endpackage

/* verilog/id_stage.sv */
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      es_allowin,
    output logic      ds_allowin,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    input  es_fwd_t   es_fwd,
    input  ms_fwd_t   ms_fwd,
    input  ws_to_rf_t ws_to_rf,
    output logic      ds_to_es_valid,
    output ds_to_es_t ds_to_es_bus,
    output br_bus_t   br_bus
);

    logic      ds_valid;
    logic      ready;
    logic      hazard_free;
    logic      cancel;
    fs_to_ds_t inst_bus;
    decode_t   dec;
    xlen_t     rdata1;
    xlen_t     rdata2;
    xlen_t     rj_value;
    xlen_t     rkd_value;

    id_stage_latch u_latch (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_to_ds_bus   (fs_to_ds_bus),
        .es_allowin     (es_allowin),
        .ready          (ready),
        .cancel         (cancel),
        .ds_valid       (ds_valid),
        .ds_allowin     (ds_allowin),
        .ds_to_es_valid (ds_to_es_valid),
        .inst_bus       (inst_bus)
    );

    inst_decoder u_decoder (
        .inst (inst_bus.inst),
        .dec  (dec)
    );

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (dec.raddr1),
        .raddr2 (dec.raddr2),
        .wr     (ws_to_rf),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    operand_forward u_forward (
        .dec       (dec),
        .es_fwd    (es_fwd),
        .ms_fwd    (ms_fwd),
        .ws_to_rf  (ws_to_rf),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .rj_value  (rj_value),
        .rkd_value (rkd_value),
        .ready     (ready)
    );

    // an empty stage holds no branch, so it never reports a stall
    assign hazard_free = ready | ~ds_valid;

    branch_unit u_branch (
        .dec            (dec),
        .pc             (inst_bus.pc),
        .rj_value       (rj_value),
        .rkd_value      (rkd_value),
        .ds_to_es_valid (ds_to_es_valid),
        .ready          (hazard_free),
        .es_allowin     (es_allowin),
        .br_bus         (br_bus),
        .cancel         (cancel)
    );

    assign ds_to_es_bus = '{
        alu_op:       dec.alu_op,
        src1_is_pc:   dec.src1_is_pc,
        src2_is_imm:  dec.src2_is_imm,
        res_from_mem: dec.res_from_mem,
        gr_we:        dec.gr_we,
        mem_we:       dec.mem_we,
        dest:         dec.dest,
        imm:          dec.imm,
        rj_value:     rj_value,
        rkd_value:    rkd_value,
        pc:           inst_bus.pc
    };

endmodule

/* verilog/id_stage_latch.sv */
`timescale 1ns/1ps

module id_stage_latch import id_pkg::*; (
    input  logic      clk,
    input  logic      reset,
    input  logic      fs_to_ds_valid,
    input  fs_to_ds_t fs_to_ds_bus,
    input  logic      es_allowin,
    input  logic      ready,
    input  logic      cancel,
    output logic      ds_valid,
    output logic      ds_allowin,
    output logic      ds_to_es_valid,
    output fs_to_ds_t inst_bus
);

    // empty, or the held instruction leaves this cycle
    assign ds_allowin     = ~ds_valid | (ready & es_allowin);
    assign ds_to_es_valid = ds_valid & ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (cancel) begin
            // wrong-path fetch is dropped at the taken edge
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            inst_bus <= fs_to_ds_bus;
        end
    end

endmodule

/* verilog/inst_decoder.sv */
`timescale 1ns/1ps

module inst_decoder import id_pkg::*; (
    input  xlen_t   inst,
    output decode_t dec
);

    op6_e        op6;
    op4_e        op4;
    logic [1:0]  op2;
    logic [4:0]  op5;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    logic [11:0] i12;
    logic [15:0] i16;
    logic [19:0] i20;
    logic [25:0] i26;
    xlen_t       si12;
    xlen_t       ui12;
    xlen_t       ui5;
    xlen_t       u20;
    xlen_t       offs16;
    xlen_t       offs26;

    assign op6 = op6_e'(inst[31:26]);
    assign op4 = op4_e'(inst[25:22]);
    assign op2 = inst[21:20];
    assign op5 = inst[19:15];

    assign rd  = inst[4:0];
    assign rj  = inst[9:5];
    assign rk  = inst[14:10];
    assign i12 = inst[21:10];
    assign i16 = inst[25:10];
    assign i20 = inst[24:5];
    assign i26 = {inst[9:0], inst[25:10]};

    assign si12   = {{20{i12[11]}}, i12};
    assign ui12   = {20'b0, i12};
    assign ui5    = {27'b0, rk};
    assign u20    = {i20, 12'b0};
    assign offs16 = {{14{i16[15]}}, i16, 2'b00};
    assign offs26 = {{4{i26[25]}}, i26, 2'b00};

    always_comb begin
        // anything unmatched falls out as a no-op: no writes, no sources
        dec         = '0;
        dec.dest    = rd;
        dec.br_offs = offs16;
        case (op6)
            OP6_GRP0: begin
                case (op4)
                    OP4_REG: begin
                        if (op2 == OP2_REG3) begin
                            dec.gr_we  = 1'b1;
                            dec.raddr1 = rj;
                            dec.raddr2 = rk;
                            case (op5)
                                OP5_ADD_W: dec.alu_op = ALU_ADD;
                                OP5_SUB_W: dec.alu_op = ALU_SUB;
                                OP5_SLT:   dec.alu_op = ALU_SLT;
                                OP5_SLTU:  dec.alu_op = ALU_SLTU;
                                OP5_NOR:   dec.alu_op = ALU_NOR;
                                OP5_AND:   dec.alu_op = ALU_AND;
                                OP5_OR:    dec.alu_op = ALU_OR;
                                OP5_XOR:   dec.alu_op = ALU_XOR;
                                OP5_SLL_W: dec.alu_op = ALU_SLL;
                                OP5_SRL_W: dec.alu_op = ALU_SRL;
                                OP5_SRA_W: dec.alu_op = ALU_SRA;
                                default: begin
                                    dec.gr_we  = 1'b0;
                                    dec.raddr1 = '0;
                                    dec.raddr2 = '0;
                                end
                            endcase
                        end
                    end
                    OP4_SHIFT: begin
                        if (op2 == OP2_SHIFT) begin
                            dec.gr_we       = 1'b1;
                            dec.src2_is_imm = 1'b1;
                            dec.raddr1      = rj;
                            dec.imm         = ui5;
                            case (op5)
                                OP5_SLLI_W: dec.alu_op = ALU_SLL;
                                OP5_SRLI_W: dec.alu_op = ALU_SRL;
                                OP5_SRAI_W: dec.alu_op = ALU_SRA;
                                default: begin
                                    dec.gr_we  = 1'b0;
                                    dec.raddr1 = '0;
                                end
                            endcase
                        end
                    end
                    OP4_SLTI, OP4_SLTUI, OP4_ADDI_W, OP4_ANDI, OP4_ORI, OP4_XORI: begin
                        dec.gr_we       = 1'b1;
                        dec.src2_is_imm = 1'b1;
                        dec.raddr1      = rj;
                        // logic ops take ui12, the rest si12
                        dec.imm         = (op4 inside {OP4_ANDI, OP4_ORI, OP4_XORI}) ? ui12 : si12;
                        case (op4)
                            OP4_SLTI:  dec.alu_op = ALU_SLT;
                            OP4_SLTUI: dec.alu_op = ALU_SLTU;
                            OP4_ANDI:  dec.alu_op = ALU_AND;
                            OP4_ORI:   dec.alu_op = ALU_OR;
                            OP4_XORI:  dec.alu_op = ALU_XOR;
                            default:   dec.alu_op = ALU_ADD;
                        endcase
                    end
                    default: ;
                endcase
            end
            OP6_LU12I_W, OP6_PCADDU12I: begin
                if (!inst[25]) begin
                    dec.gr_we       = 1'b1;
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = u20;
                    dec.src1_is_pc  = (op6 == OP6_PCADDU12I);
                    dec.alu_op      = (op6 == OP6_PCADDU12I) ? ALU_ADD : ALU_LUI;
                end
            end
            OP6_MEM: begin
                if (op4 == OP4_LD_W || op4 == OP4_ST_W) begin
                    dec.src2_is_imm = 1'b1;
                    dec.imm         = si12;
                    dec.raddr1      = rj;
                    dec.res_from_mem = (op4 == OP4_LD_W);
                    dec.gr_we        = (op4 == OP4_LD_W);
                    dec.mem_we       = (op4 == OP4_ST_W);
                    // store data comes from rd
                    dec.raddr2       = (op4 == OP4_ST_W) ? rd : '0;
                end
            end
            OP6_JIRL, OP6_BL: begin
                // link value is pc + 4
                dec.gr_we       = 1'b1;
                dec.src1_is_pc  = 1'b1;
                dec.src2_is_imm = 1'b1;
                dec.imm         = 32'd4;
                if (op6 == OP6_JIRL) begin
                    dec.br_kind = BR_JIRL;
                    dec.raddr1  = rj;
                end else begin
                    dec.br_kind = BR_BL;
                    dec.dest    = 5'd1;
                    dec.br_offs = offs26;
                end
            end
            OP6_B: begin
                dec.br_kind = BR_B;
                dec.br_offs = offs26;
            end
            OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU: begin
                dec.raddr1 = rj;
                dec.raddr2 = rd;
                case (op6)
                    OP6_BEQ:  dec.br_kind = BR_BEQ;
                    OP6_BNE:  dec.br_kind = BR_BNE;
                    OP6_BLT:  dec.br_kind = BR_BLT;
                    OP6_BGE:  dec.br_kind = BR_BGE;
                    OP6_BLTU: dec.br_kind = BR_BLTU;
                    default:  dec.br_kind = BR_BGEU;
                endcase
            end
            default: ;
        endcase
    end

endmodule

/* verilog/operand_forward.sv */
`timescale 1ns/1ps

module operand_forward import id_pkg::*; (
    input  decode_t   dec,
    input  es_fwd_t   es_fwd,
    input  ms_fwd_t   ms_fwd,
    input  ws_to_rf_t ws_to_rf,
    input  xlen_t     rdata1,
    input  xlen_t     rdata2,
    output xlen_t     rj_value,
    output xlen_t     rkd_value,
    output logic      ready
);

    logic load_use;

    // youngest producer wins, r0 never matches
    function automatic xlen_t fwd_sel(
        input reg_addr_t addr,
        input xlen_t     rf_data,
        input es_fwd_t   es,
        input ms_fwd_t   ms,
        input ws_to_rf_t ws
    );
        xlen_t res;
        res = rf_data;
        if (addr != '0) begin
            if (es.valid && es.dest == addr) begin
                res = es.data;
            end else if (ms.valid && ms.dest == addr) begin
                res = ms.data;
            end else if (ws.we && ws.waddr == addr) begin
                res = ws.wdata;
            end
        end
        return res;
    endfunction

    assign rj_value  = fwd_sel(dec.raddr1, rdata1, es_fwd, ms_fwd, ws_to_rf);
    assign rkd_value = fwd_sel(dec.raddr2, rdata2, es_fwd, ms_fwd, ws_to_rf);

    // load still in execute, data not back yet
    assign load_use = es_fwd.blk && es_fwd.dest != '0
                      && (es_fwd.dest == dec.raddr1 || es_fwd.dest == dec.raddr2);

    assign ready = ~load_use;

endmodule

/* verilog/regfile.sv */
`timescale 1ns/1ps

module regfile import id_pkg::*; (
    input  logic      clk,
    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    input  ws_to_rf_t wr,
    output xlen_t     rdata1,
    output xlen_t     rdata2
);

    xlen_t rf [32];

    // r0 is never written
    always_ff @(posedge clk) begin
        if (wr.we && wr.waddr != '0) begin
            rf[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : rf[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : rf[raddr2];

endmodule
